//--- side_ch_pkg.sv
// shared widths and encodings; register addresses are fixed by the software register map
package side_ch_pkg;

	// sample and bus widths
	localparam int IQ_DATA_WIDTH = 16;
	localparam int SAMPLE_WIDTH = 2 * IQ_DATA_WIDTH;
	localparam int WORD_WIDTH = 64;
	localparam int REG_DATA_WIDTH = 32;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int RSSI_WIDTH = 11;
	localparam int NUM_EVENTS = 6;
	localparam int LEN_WIDTH = 13;

	// register map
	typedef enum logic [REG_ADDR_WIDTH-1:0] {
		REG_CTRL = 5'd0,
		REG_NUM_DMA = 5'd2,
		REG_CAPTURE = 5'd3,
		REG_TRIG_SEL = 5'd8,
		REG_RSSI_TH = 5'd9,
		REG_IQ_LEN = 5'd12,
		REG_EVENT_SEL = 5'd19,
		REG_FIFO_LEVEL = 5'd20,
		REG_DROP_CNT = 5'd21,
		REG_CNT0 = 5'd26,
		REG_CNT1 = 5'd27,
		REG_CNT2 = 5'd28,
		REG_CNT3 = 5'd29,
		REG_CNT4 = 5'd30,
		REG_CNT5 = 5'd31
	} reg_addr_e;

	// capture trigger sources
	typedef enum logic [1:0] {
		TRIG_FREE_RUN = 2'd0,
		TRIG_RSSI = 2'd1,
		TRIG_SHORT_PREAMBLE = 2'd2,
		TRIG_FCS_OK = 2'd3
	} trig_sel_e;

	// capture fsm
	typedef enum logic [1:0] {
		CAP_IDLE,
		CAP_WAIT_TRIG,
		CAP_CAPTURE
	} cap_state_e;

endpackage

//--- side_ch_regs.sv
// writes take effect next cycle; reads are combinational and unmapped addresses return zero
`timescale 1ns/1ns

module side_ch_regs #(
	parameter int FIFO_DEPTH = 64,
	parameter int COUNTER_WIDTH = 16
) (
	input  logic clk,
	input  logic rst_n,
	input  logic reg_wr,
	input  logic [side_ch_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
	input  logic [side_ch_pkg::REG_DATA_WIDTH-1:0] reg_wdata,
	input  logic [side_ch_pkg::NUM_EVENTS-1:0][COUNTER_WIDTH-1:0] counters,
	input  logic [side_ch_pkg::REG_DATA_WIDTH-1:0] drop_cnt,
	input  logic [$clog2(FIFO_DEPTH):0] fifo_level,
	output logic [side_ch_pkg::REG_DATA_WIDTH-1:0] reg_rdata,
	output logic capture_en,
	output side_ch_pkg::trig_sel_e trig_sel,
	output logic signed [side_ch_pkg::RSSI_WIDTH-1:0] rssi_th,
	output logic [side_ch_pkg::LEN_WIDTH-1:0] iq_len,
	output logic [side_ch_pkg::LEN_WIDTH-1:0] num_dma,
	output logic [side_ch_pkg::NUM_EVENTS-1:0] event_sel,
	output logic stream_flush,
	output logic cap_reset,
	output logic [side_ch_pkg::NUM_EVENTS-1:0] cnt_clear
);

	localparam int LEVEL_WIDTH = $clog2(FIFO_DEPTH) + 1;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			capture_en <= 1'b0;
			trig_sel <= side_ch_pkg::TRIG_FREE_RUN;
			rssi_th <= '0;
			iq_len <= '0;
			num_dma <= '0;
			event_sel <= '0;
			stream_flush <= 1'b0;
			cap_reset <= 1'b0;
		end
		else if (reg_wr)
		begin
			case (reg_addr)
				side_ch_pkg::REG_CTRL:
				begin
					// both bits are levels, software sets and later clears them
					stream_flush <= reg_wdata[0];
					cap_reset <= reg_wdata[2];
				end
				side_ch_pkg::REG_CAPTURE: capture_en <= reg_wdata[0];
				side_ch_pkg::REG_TRIG_SEL: trig_sel <= side_ch_pkg::trig_sel_e'(reg_wdata[1:0]);
				side_ch_pkg::REG_RSSI_TH: rssi_th <= reg_wdata[side_ch_pkg::RSSI_WIDTH-1:0];
				side_ch_pkg::REG_IQ_LEN: iq_len <= reg_wdata[side_ch_pkg::LEN_WIDTH-1:0];
				side_ch_pkg::REG_NUM_DMA: num_dma <= reg_wdata[side_ch_pkg::LEN_WIDTH-1:0];
				side_ch_pkg::REG_EVENT_SEL: event_sel <= reg_wdata[side_ch_pkg::NUM_EVENTS-1:0];
				default: ;
			endcase
		end
	end

	// a write to a counter address clears that counter on the next edge
	always_comb
	begin
		for (int k = 0; k < side_ch_pkg::NUM_EVENTS; k++)
			cnt_clear[k] = reg_wr && (reg_addr == side_ch_pkg::REG_CNT0 + k);
	end

	always_comb
	begin
		reg_rdata = '0;
		case (reg_addr)
			side_ch_pkg::REG_CTRL:
			begin
				reg_rdata[0] = stream_flush;
				reg_rdata[2] = cap_reset;
			end
			side_ch_pkg::REG_CAPTURE: reg_rdata[0] = capture_en;
			side_ch_pkg::REG_TRIG_SEL: reg_rdata[1:0] = trig_sel;
			side_ch_pkg::REG_RSSI_TH: reg_rdata[side_ch_pkg::RSSI_WIDTH-1:0] = rssi_th;
			side_ch_pkg::REG_IQ_LEN: reg_rdata[side_ch_pkg::LEN_WIDTH-1:0] = iq_len;
			side_ch_pkg::REG_NUM_DMA: reg_rdata[side_ch_pkg::LEN_WIDTH-1:0] = num_dma;
			side_ch_pkg::REG_EVENT_SEL: reg_rdata[side_ch_pkg::NUM_EVENTS-1:0] = event_sel;
			side_ch_pkg::REG_FIFO_LEVEL: reg_rdata[LEVEL_WIDTH-1:0] = fifo_level;
			side_ch_pkg::REG_DROP_CNT: reg_rdata = drop_cnt;
			side_ch_pkg::REG_CNT0: reg_rdata[COUNTER_WIDTH-1:0] = counters[0];
			side_ch_pkg::REG_CNT1: reg_rdata[COUNTER_WIDTH-1:0] = counters[1];
			side_ch_pkg::REG_CNT2: reg_rdata[COUNTER_WIDTH-1:0] = counters[2];
			side_ch_pkg::REG_CNT3: reg_rdata[COUNTER_WIDTH-1:0] = counters[3];
			side_ch_pkg::REG_CNT4: reg_rdata[COUNTER_WIDTH-1:0] = counters[4];
			side_ch_pkg::REG_CNT5: reg_rdata[COUNTER_WIDTH-1:0] = counters[5];
			default: ;
		endcase
	end

endmodule

//--- side_ch_event_cnt.sv
// events count every cycle they are high; counters wrap and a clear beats a coinciding event
`timescale 1ns/1ns

module side_ch_event_cnt #(
	parameter int COUNTER_WIDTH = 16
) (
	input  logic clk,
	input  logic rst_n,
	input  logic signed [side_ch_pkg::RSSI_WIDTH-1:0] rssi_half_db,
	input  logic signed [side_ch_pkg::RSSI_WIDTH-1:0] rssi_th,
	input  logic short_preamble_detected,
	input  logic long_preamble_detected,
	input  logic pkt_header_valid_strobe,
	input  logic pkt_header_valid,
	input  logic fcs_in_strobe,
	input  logic fcs_ok,
	input  logic phy_tx_start,
	input  logic tx_pkt_need_ack,
	input  logic phy_tx_done,
	input  logic [side_ch_pkg::NUM_EVENTS-1:0] event_sel,
	input  logic [side_ch_pkg::NUM_EVENTS-1:0] cnt_clear,
	output logic [side_ch_pkg::NUM_EVENTS-1:0][COUNTER_WIDTH-1:0] counters
);

	logic rssi_above;
	logic [side_ch_pkg::NUM_EVENTS-1:0] raw_event;
	logic [side_ch_pkg::NUM_EVENTS-1:0] qualifier;
	logic [side_ch_pkg::NUM_EVENTS-1:0] event_hit;

	// signed half-dB compare
	assign rssi_above = rssi_half_db > rssi_th;

	// event k sits on bit k
	assign raw_event = {
		phy_tx_done,
		phy_tx_start,
		fcs_in_strobe,
		pkt_header_valid_strobe,
		long_preamble_detected,
		short_preamble_detected
	};

	assign qualifier = {
		rssi_above,
		tx_pkt_need_ack,
		fcs_ok,
		pkt_header_valid,
		rssi_above,
		rssi_above
	};

	// qualifier only applies when its select bit is set
	assign event_hit = raw_event & (~event_sel | qualifier);

	always_ff @(posedge clk)
	begin
		for (int k = 0; k < side_ch_pkg::NUM_EVENTS; k++)
		begin
			if (!rst_n || cnt_clear[k])
				counters[k] <= '0;
			else if (event_hit[k])
				counters[k] <= counters[k] + 1'b1;
		end
	end

endmodule

//--- side_ch_control.sv
// no pre-trigger history; fifo_full is taken as full for the push one cycle ahead
`timescale 1ns/1ns

module side_ch_control #(
	parameter int FIFO_DEPTH = 64
) (
	input  logic clk,
	input  logic rst_n,
	input  logic cap_reset,
	input  logic capture_en,
	input  side_ch_pkg::trig_sel_e trig_sel,
	input  logic signed [side_ch_pkg::RSSI_WIDTH-1:0] rssi_th,
	input  logic [side_ch_pkg::LEN_WIDTH-1:0] iq_len,
	input  logic signed [side_ch_pkg::RSSI_WIDTH-1:0] rssi_half_db,
	input  logic short_preamble_detected,
	input  logic fcs_in_strobe,
	input  logic fcs_ok,
	input  logic [side_ch_pkg::SAMPLE_WIDTH-1:0] sample0_in,
	input  logic [side_ch_pkg::SAMPLE_WIDTH-1:0] sample1_in,
	input  logic sample_in_strobe,
	input  logic fifo_full,
	output logic fifo_push,
	output logic [side_ch_pkg::WORD_WIDTH-1:0] fifo_wdata,
	output logic [side_ch_pkg::REG_DATA_WIDTH-1:0] drop_cnt
);

	localparam int IQ = side_ch_pkg::IQ_DATA_WIDTH;

	side_ch_pkg::cap_state_e state;
	logic [side_ch_pkg::LEN_WIDTH-1:0] sample_cnt;
	logic trig_hit;
	logic cap_strobe;
	logic last_sample;

	// pointer wrap in the fifo relies on this
	if ((FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0)
	begin : g_depth_check
		$error("FIFO_DEPTH is not a power of two");
	end

	always_comb
	begin
		case (trig_sel)
			side_ch_pkg::TRIG_FREE_RUN: trig_hit = 1'b1;
			side_ch_pkg::TRIG_RSSI: trig_hit = rssi_half_db > rssi_th;
			side_ch_pkg::TRIG_SHORT_PREAMBLE: trig_hit = short_preamble_detected;
			side_ch_pkg::TRIG_FCS_OK: trig_hit = fcs_in_strobe && fcs_ok;
			default: trig_hit = 1'b0;
		endcase
	end

	assign cap_strobe = (state == side_ch_pkg::CAP_CAPTURE) && sample_in_strobe;
	// dropped strobes count toward iq_len as well
	assign last_sample = sample_cnt == iq_len - 1'b1;

	always_ff @(posedge clk)
	begin
		if (!rst_n || cap_reset)
		begin
			state <= side_ch_pkg::CAP_IDLE;
			sample_cnt <= '0;
		end
		else
		begin
			case (state)
				side_ch_pkg::CAP_IDLE:
					if (capture_en)
						state <= side_ch_pkg::CAP_WAIT_TRIG;
				side_ch_pkg::CAP_WAIT_TRIG:
				begin
					sample_cnt <= '0;
					if (!capture_en)
						state <= side_ch_pkg::CAP_IDLE;
					else if (trig_hit)
						state <= side_ch_pkg::CAP_CAPTURE;
				end
				side_ch_pkg::CAP_CAPTURE:
					if (sample_in_strobe)
					begin
						if (last_sample)
						begin
							sample_cnt <= '0;
							// rearm when capture stays enabled
							state <= capture_en ? side_ch_pkg::CAP_WAIT_TRIG : side_ch_pkg::CAP_IDLE;
						end
						else
							sample_cnt <= sample_cnt + 1'b1;
					end
				default: state <= side_ch_pkg::CAP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n || cap_reset)
		begin
			fifo_push <= 1'b0;
			drop_cnt <= '0;
		end
		else
		begin
			fifo_push <= cap_strobe && !fifo_full;
			if (cap_strobe && fifo_full)
				drop_cnt <= drop_cnt + 1'b1;
		end
	end

	// I and Q halves swapped, sample1 in the upper half of the word
	always_ff @(posedge clk)
	begin
		if (cap_strobe)
			fifo_wdata <= {sample1_in[IQ-1:0], sample1_in[2*IQ-1:IQ],
				sample0_in[IQ-1:0], sample0_in[2*IQ-1:IQ]};
	end

endmodule

//--- side_ch_fifo.sv
// first-word-fall-through; fifo_full looks one cycle ahead to cover the registered push
`timescale 1ns/1ns

module side_ch_fifo #(
	parameter int FIFO_DEPTH = 64
) (
	input  logic clk,
	input  logic rst_n,
	input  logic stream_flush,
	input  logic fifo_push,
	input  logic [side_ch_pkg::WORD_WIDTH-1:0] fifo_wdata,
	input  logic fifo_pop,
	output logic [side_ch_pkg::WORD_WIDTH-1:0] fifo_rdata,
	output logic fifo_empty,
	output logic fifo_full,
	output logic [$clog2(FIFO_DEPTH):0] fifo_level
);

	localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int LEVEL_WIDTH = ADDR_WIDTH + 1;

	logic [side_ch_pkg::WORD_WIDTH-1:0] mem [FIFO_DEPTH];
	logic [ADDR_WIDTH-1:0] wr_ptr;
	logic [ADDR_WIDTH-1:0] rd_ptr;
	logic [LEVEL_WIDTH-1:0] next_level;
	logic wr_en;
	logic rd_en;

	assign rd_en = fifo_pop && !fifo_empty;
	// push into a full buffer only when a pop frees a slot the same cycle
	assign wr_en = fifo_push && ((fifo_level != FIFO_DEPTH) || rd_en);
	assign next_level = fifo_level + LEVEL_WIDTH'(wr_en) - LEVEL_WIDTH'(rd_en);

	assign fifo_empty = fifo_level == '0;
	assign fifo_full = next_level == FIFO_DEPTH;
	assign fifo_rdata = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= fifo_wdata;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n || stream_flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_level <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			fifo_level <= next_level;
		end
	end

endmodule

//--- side_ch_m_axis.sv
// no tstrb; num_dma of zero places tlast only after the beat counter wraps
`timescale 1ns/1ns

module side_ch_m_axis (
	input  logic clk,
	input  logic rst_n,
	input  logic stream_flush,
	input  logic [side_ch_pkg::LEN_WIDTH-1:0] num_dma,
	input  logic [side_ch_pkg::WORD_WIDTH-1:0] fifo_rdata,
	input  logic fifo_empty,
	input  logic m_axis_tready,
	output logic fifo_pop,
	output logic m_axis_tvalid,
	output logic [side_ch_pkg::WORD_WIDTH-1:0] m_axis_tdata,
	output logic m_axis_tlast
);

	logic [side_ch_pkg::LEN_WIDTH-1:0] beat_cnt;
	logic block_end;

	// fifo head is the current beat
	assign m_axis_tvalid = !fifo_empty;
	assign m_axis_tdata = fifo_rdata;
	assign fifo_pop = m_axis_tvalid && m_axis_tready;

	assign block_end = beat_cnt == num_dma - 1'b1;
	assign m_axis_tlast = m_axis_tvalid && block_end;

	// beat index within the current dma block
	always_ff @(posedge clk)
	begin
		if (!rst_n || stream_flush)
			beat_cnt <= '0;
		else if (fifo_pop)
		begin
			if (block_end)
				beat_cnt <= '0;
			else
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

endmodule

//--- side_ch.sv
// single clock domain; plain register strobe in place of axi-lite, receive iq capture only
`timescale 1ns/1ns

module side_ch #(
	parameter int FIFO_DEPTH = 64,
	parameter int COUNTER_WIDTH = 16
) (
	input  logic clk,
	input  logic rst_n,
	input  logic reg_wr,
	input  logic [side_ch_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
	input  logic [side_ch_pkg::REG_DATA_WIDTH-1:0] reg_wdata,
	output logic [side_ch_pkg::REG_DATA_WIDTH-1:0] reg_rdata,
	input  logic signed [side_ch_pkg::RSSI_WIDTH-1:0] rssi_half_db,
	input  logic short_preamble_detected,
	input  logic long_preamble_detected,
	input  logic pkt_header_valid_strobe,
	input  logic pkt_header_valid,
	input  logic fcs_in_strobe,
	input  logic fcs_ok,
	input  logic phy_tx_start,
	input  logic tx_pkt_need_ack,
	input  logic phy_tx_done,
	input  logic [side_ch_pkg::SAMPLE_WIDTH-1:0] sample0_in,
	input  logic [side_ch_pkg::SAMPLE_WIDTH-1:0] sample1_in,
	input  logic sample_in_strobe,
	output logic m_axis_tvalid,
	output logic [side_ch_pkg::WORD_WIDTH-1:0] m_axis_tdata,
	output logic m_axis_tlast,
	input  logic m_axis_tready
);

	// configuration from the register file
	logic capture_en;
	side_ch_pkg::trig_sel_e trig_sel;
	logic signed [side_ch_pkg::RSSI_WIDTH-1:0] rssi_th;
	logic [side_ch_pkg::LEN_WIDTH-1:0] iq_len;
	logic [side_ch_pkg::LEN_WIDTH-1:0] num_dma;
	logic [side_ch_pkg::NUM_EVENTS-1:0] event_sel;
	logic stream_flush;
	logic cap_reset;
	logic [side_ch_pkg::NUM_EVENTS-1:0] cnt_clear;

	// status
	logic [side_ch_pkg::NUM_EVENTS-1:0][COUNTER_WIDTH-1:0] counters;
	logic [side_ch_pkg::REG_DATA_WIDTH-1:0] drop_cnt;
	logic [$clog2(FIFO_DEPTH):0] fifo_level;

	// sample path
	logic fifo_push;
	logic [side_ch_pkg::WORD_WIDTH-1:0] fifo_wdata;
	logic fifo_full;
	logic fifo_pop;
	logic [side_ch_pkg::WORD_WIDTH-1:0] fifo_rdata;
	logic fifo_empty;

	side_ch_regs #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.COUNTER_WIDTH(COUNTER_WIDTH)
	) u_regs (.*);

	side_ch_event_cnt #(
		.COUNTER_WIDTH(COUNTER_WIDTH)
	) u_event_cnt (.*);

	side_ch_control #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_control (.*);

	side_ch_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (.*);

	side_ch_m_axis u_m_axis (.*);

endmodule

//--- side_ch_sva.sv
// bound to side_ch_m_axis; a stream flush may drop a stalled beat, so flush disables the hold check
`timescale 1ns/1ns

module side_ch_sva (
	input  logic clk,
	input  logic rst_n,
	input  logic stream_flush,
	input  logic m_axis_tready,
	input  logic m_axis_tvalid,
	input  logic [side_ch_pkg::WORD_WIDTH-1:0] m_axis_tdata,
	input  logic m_axis_tlast
);

	// stream quiet right after reset
	a_reset_quiet: assert property (@(posedge clk) !rst_n |=> (!m_axis_tvalid && !m_axis_tlast))
	else
		$error("tvalid or tlast high in the cycle after reset");

	// a stalled beat holds until accepted
	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n || stream_flush)
		(m_axis_tvalid && !m_axis_tready) |=>
		(m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
	else
		$error("stream beat changed while stalled");

endmodule

bind side_ch_m_axis side_ch_sva u_sva (.*);

//--- tb_side_ch.sv
// testbench with FIFO_DEPTH 16; table rows keep iq_len below the depth, overflow has its own section
`timescale 1ns/1ns

module tb_side_ch;

	localparam int DEPTH = 16;
	localparam int SPACING = 2;
	localparam int MARGIN = 4000;
	localparam int NUM_ROWS = 5;
	localparam logic [10:0] RSSI_FLOOR = 11'h400;

	typedef struct packed {
		logic [1:0] trig;
		logic [10:0] th;
		logic [10:0] rssi;
		logic [12:0] iq_len;
		logic [12:0] num_dma;
		logic [5:0] event_sel;
		logic [3:0] duty;
		logic [12:0] count;
	} row_t;

	logic clk;
	logic rst_n;
	logic reg_wr;
	logic [4:0] reg_addr;
	logic [31:0] reg_wdata;
	logic [31:0] reg_rdata;
	logic [10:0] rssi_half_db;
	logic short_preamble_detected;
	logic long_preamble_detected;
	logic pkt_header_valid_strobe;
	logic pkt_header_valid;
	logic fcs_in_strobe;
	logic fcs_ok;
	logic phy_tx_start;
	logic tx_pkt_need_ack;
	logic phy_tx_done;
	logic [31:0] sample0_in;
	logic [31:0] sample1_in;
	logic sample_in_strobe;
	logic m_axis_tvalid;
	logic [63:0] m_axis_tdata;
	logic m_axis_tlast;
	logic m_axis_tready;

	row_t rows [NUM_ROWS];
	logic [63:0] exp_q [$];
	logic [31:0] lfsr;
	logic [31:0] rdy_lfsr;
	int beat_idx;
	int cur_dma;
	int duty;
	int errors;
	int beat_errors;
	int cycles;
	int limit;

	side_ch #(
		.FIFO_DEPTH(DEPTH),
		.COUNTER_WIDTH(16)
	) UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic next_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check(input logic [63:0] actual, input logic [63:0] expected, input string msg);
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, actual, expected);
		end
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		@(posedge clk);
		reg_wr <= 1'b1;
		reg_addr <= addr;
		reg_wdata <= data;
		@(posedge clk);
		reg_wr <= 1'b0;
	endtask

	task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
		@(posedge clk);
		reg_addr <= addr;
		@(posedge clk);
		data = reg_rdata;
	endtask

	task automatic expect_reg(input logic [4:0] addr, input logic [31:0] value, input string msg);
		logic [31:0] rd;
		read_reg(addr, rd);
		check(rd, value, msg);
	endtask

	// one strobe plus one idle cycle; returns the half-swapped word
	task automatic drive_strobe(output logic [63:0] word);
		logic [31:0] s0;
		logic [31:0] s1;
		next_bits(32, s0);
		next_bits(32, s1);
		word = {s1[15:0], s1[31:16], s0[15:0], s0[31:16]};
		@(posedge clk);
		sample0_in <= s0;
		sample1_in <= s1;
		sample_in_strobe <= 1'b1;
		@(posedge clk);
		sample_in_strobe <= 1'b0;
	endtask

	task automatic pulse_trigger(input logic [1:0] trig, input logic [10:0] rssi);
		@(posedge clk);
		case (trig)
			2'd1: rssi_half_db <= rssi;
			2'd2: short_preamble_detected <= 1'b1;
			2'd3:
			begin
				fcs_in_strobe <= 1'b1;
				fcs_ok <= 1'b1;
			end
			default: ;
		endcase
		@(posedge clk);
		rssi_half_db <= RSSI_FLOOR;
		short_preamble_detected <= 1'b0;
		fcs_in_strobe <= 1'b0;
		fcs_ok <= 1'b0;
		@(posedge clk);
	endtask

	// turn capture off and return the fsm and stream path to idle
	task automatic start_section();
		write_reg(5'd3, 32'd0);
		write_reg(5'd0, 32'd5);
		write_reg(5'd0, 32'd0);
		beat_idx = 0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || m_axis_tvalid)
			@(posedge clk);
	endtask

	task automatic check_regs();
		logic [4:0] addrs [7];
		logic [31:0] masks [7];
		addrs = '{5'd3, 5'd8, 5'd9, 5'd12, 5'd2, 5'd19, 5'd0};
		masks = '{32'h1, 32'h3, 32'h7ff, 32'h1fff, 32'h1fff, 32'h3f, 32'h5};
		for (int i = 0; i < 7; i++)
		begin
			write_reg(addrs[i], 32'hffff_ffff);
			expect_reg(addrs[i], masks[i], "register read-back");
		end
		for (int i = 0; i < 7; i++)
			write_reg(addrs[i], 32'd0);
		expect_reg(5'd1, 32'd0, "unmapped address 1");
		expect_reg(5'd5, 32'd0, "unmapped address 5");
	endtask

	task automatic count_events(input row_t row, input int c);
		int exp_cnt [6];
		logic [31:0] b;
		logic [5:0] raw;
		logic [3:0] q;
		logic [5:0] qv;
		for (int k = 0; k < 6; k++)
		begin
			write_reg(5'(26 + k), 32'd0);
			exp_cnt[k] = 0;
		end
		repeat (8)
		begin
			next_bits(6, b);
			raw = b[5:0];
			next_bits(4, b);
			q = b[3:0];
			// rssi, rssi, header valid, fcs ok, need ack, rssi
			qv = {q[0], q[3], q[2], q[1], q[0], q[0]};
			for (int k = 0; k < 6; k++)
				if (raw[k] && (!row.event_sel[k] || qv[k]))
					exp_cnt[k]++;
			@(posedge clk);
			short_preamble_detected <= raw[0];
			long_preamble_detected <= raw[1];
			pkt_header_valid_strobe <= raw[2];
			fcs_in_strobe <= raw[3];
			phy_tx_start <= raw[4];
			phy_tx_done <= raw[5];
			rssi_half_db <= q[0] ? row.th + 11'd5 : row.th - 11'd5;
			pkt_header_valid <= q[1];
			fcs_ok <= q[2];
			tx_pkt_need_ack <= q[3];
			@(posedge clk);
			{short_preamble_detected, long_preamble_detected, pkt_header_valid_strobe} <= '0;
			{fcs_in_strobe, phy_tx_start, phy_tx_done} <= '0;
			{pkt_header_valid, fcs_ok, tx_pkt_need_ack} <= '0;
			rssi_half_db <= RSSI_FLOOR;
		end
		for (int k = 0; k < 6; k++)
			expect_reg(5'(26 + k), exp_cnt[k], "event counter");
		write_reg(5'(26 + c), 32'd0);
		exp_cnt[c] = 0;
		for (int k = 0; k < 6; k++)
			expect_reg(5'(26 + k), exp_cnt[k], "counter after clear");
	endtask

	task automatic run_row(input int r);
		row_t row;
		logic [63:0] word;
		row = rows[r];
		start_section();
		write_reg(5'd8, row.trig);
		write_reg(5'd9, row.th);
		write_reg(5'd12, row.iq_len);
		write_reg(5'd2, row.num_dma);
		write_reg(5'd19, row.event_sel);
		expect_reg(5'd12, row.iq_len, "iq_len read-back");
		cur_dma = row.num_dma;
		duty = row.duty;
		count_events(row, r % 6);
		write_reg(5'd3, 32'd1);
		repeat (2) @(posedge clk);
		// strobes ahead of the trigger must be ignored
		for (int i = 0; i < row.count - row.iq_len; i++)
			drive_strobe(word);
		pulse_trigger(row.trig, row.rssi);
		for (int i = 0; i < row.iq_len; i++)
		begin
			drive_strobe(word);
			exp_q.push_back(word);
		end
		// strobes after the last captured one wait for a new trigger
		for (int i = 0; i < row.count - row.iq_len; i++)
			drive_strobe(word);
		wait_drain();
	endtask

	task automatic overflow_and_flush();
		logic [63:0] word;
		start_section();
		duty = 0;
		write_reg(5'd8, 32'd0);
		write_reg(5'd12, DEPTH + 5);
		write_reg(5'd2, 32'd5);
		cur_dma = 5;
		write_reg(5'd3, 32'd1);
		repeat (2) @(posedge clk);
		for (int i = 0; i < DEPTH + 5; i++)
		begin
			drive_strobe(word);
			if (i < DEPTH)
				exp_q.push_back(word);
		end
		write_reg(5'd3, 32'd0);
		expect_reg(5'd20, DEPTH, "fifo level when full");
		expect_reg(5'd21, 32'd5, "drop count");
		write_reg(5'd0, 32'd4);
		write_reg(5'd0, 32'd0);
		expect_reg(5'd21, 32'd0, "drop count after capture reset");
		// armed without a trigger so nothing may be captured or dropped
		write_reg(5'd8, 32'd2);
		write_reg(5'd3, 32'd1);
		repeat (3) drive_strobe(word);
		expect_reg(5'd20, DEPTH, "fifo level without trigger");
		expect_reg(5'd21, 32'd0, "drop count without trigger");
		duty = 8;
		wait_drain();
		// leaves the beat counter mid block so the flush must restart it
		duty = 0;
		write_reg(5'd12, 32'd4);
		pulse_trigger(2'd2, RSSI_FLOOR);
		repeat (4) drive_strobe(word);
		expect_reg(5'd20, 32'd4, "fifo level before flush");
		write_reg(5'd2, 32'd3);
		write_reg(5'd0, 32'd1);
		write_reg(5'd0, 32'd0);
		beat_idx = 0;
		cur_dma = 3;
		expect_reg(5'd20, 32'd0, "fifo level after flush");
		check(m_axis_tvalid, 1'b0, "tvalid after flush");
		duty = 8;
		pulse_trigger(2'd2, RSSI_FLOOR);
		for (int i = 0; i < 4; i++)
		begin
			drive_strobe(word);
			exp_q.push_back(word);
		end
		wait_drain();
	endtask

	// random ready with a duty of duty/8
	always @(posedge clk)
	begin
		logic [2:0] b;
		for (int i = 0; i < 3; i++)
		begin
			rdy_lfsr = lfsr_step(rdy_lfsr);
			b = {b[1:0], rdy_lfsr[0]};
		end
		m_axis_tready <= (int'(b) < duty);
	end

	// stream monitor against the expected word queue
	always @(posedge clk)
	begin
		if (rst_n && m_axis_tvalid && m_axis_tready)
		begin
			if (exp_q.size() == 0)
			begin
				beat_errors++;
				$display("stream beat at %0t arrived with no captured word expected", $time);
			end
			else
			begin
				check(m_axis_tdata, exp_q.pop_front(), "stream data");
				check(m_axis_tlast, (beat_idx % cur_dma) == cur_dma - 1, "tlast");
				beat_idx++;
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles == limit)
		begin
			$display("run timed out after %0d cycles", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial
	begin
		lfsr = 32'h0aac513e;
		rdy_lfsr = 32'h0aac513e;
		rows[0] = '{2'd0, 11'd0, 11'd0, 13'd6, 13'd4, 6'h00, 4'd8, 13'd6};
		rows[1] = '{2'd1, 11'(-200), 11'(-100), 13'd9, 13'd3, 6'h3f, 4'd5, 13'd11};
		rows[2] = '{2'd2, 11'd50, 11'd0, 13'd12, 13'd5, 6'h15, 4'd3, 13'd14};
		rows[3] = '{2'd3, 11'(-50), 11'd0, 13'd7, 13'd2, 6'h2a, 4'd8, 13'd10};
		rows[4] = '{2'd0, 11'd10, 11'd0, 13'd10, 13'd1, 6'h3f, 4'd2, 13'd10};
		limit = 2 * (DEPTH + 5 + 3 + 4 + 4) * SPACING + MARGIN;
		for (int r = 0; r < NUM_ROWS; r++)
			limit += 2 * rows[r].count * SPACING;
		cycles = 0;
		errors = 0;
		beat_errors = 0;
		beat_idx = 0;
		cur_dma = 1;
		duty = 8;
		rst_n = 1'b0;
		reg_wr = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		rssi_half_db = RSSI_FLOOR;
		{short_preamble_detected, long_preamble_detected, pkt_header_valid_strobe} = '0;
		{pkt_header_valid, fcs_in_strobe, fcs_ok} = '0;
		{phy_tx_start, tx_pkt_need_ack, phy_tx_done} = '0;
		sample0_in = '0;
		sample1_in = '0;
		sample_in_strobe = 1'b0;
		m_axis_tready = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		check_regs();
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		overflow_and_flush();
		repeat (4) @(posedge clk);
		$display("errors: %0d value mismatches, %0d unexpected beats", errors, beat_errors);
		if (errors == 0 && beat_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- side_ch.f
side_ch_pkg.sv
side_ch_regs.sv
side_ch_event_cnt.sv
side_ch_control.sv
side_ch_fifo.sv
side_ch_m_axis.sv
side_ch.sv
side_ch_sva.sv
tb_side_ch.sv

//--- run_sim.sh
#!/bin/bash
# builds and runs tb_side_ch with Verilator, passes only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_side_ch -f side_ch.f -o sim_side_ch \
	&& ./obj_dir/sim_side_ch > sim.log 2>&1
cat sim.log
grep -qx "SIMULATION PASSED" sim.log && echo "run ok" || { echo "run failed"; exit 1; }
